/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - lsu_pkg.sv
      - lsu_op_if.sv
      - lsu_stage_reg.sv
      - lsu_lane_align.sv
      - lsu_bus_master.sv
      - lsu_trap_flush.sv
      - lsu_top.sv
  - target: test
    files:
      - lsu_tb_mem.sv
      - lsu_tb.sv

/* lsu_bus_master.sv */
`timescale 1ns/100ps

module lsu_bus_master import lsu_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  lsu_op_if.bus   op,
  input  logic    ld_misalign,
  input  logic    st_misalign,
  input  logic    flush,
  input  size_t   size,
  input  strb_t   strb,
  input  word_t   wdata_lane,
  // read address
  output logic    ar_valid,
  output word_t   ar_addr,
  output size_t   ar_size,
  input  logic    ar_ready,
  // read data
  input  logic    r_valid,
  input  word_t   r_data,
  input  resp_t   r_resp,
  output logic    r_ready,
  // write address
  output logic    aw_valid,
  output word_t   aw_addr,
  output size_t   aw_size,
  input  logic    aw_ready,
  // write data
  output logic    w_valid,
  output word_t   w_data,
  output strb_t   w_strb,
  input  logic    w_ready,
  // write response
  input  logic    b_valid,
  input  resp_t   b_resp,
  output logic    b_ready,
  // toward the rest of the stage
  output word_t   rdata,
  output logic    retire,
  output logic    ld_fault,
  output logic    st_fault
);

  logic  is_mem;
  logic  start_ok;
  logic  issue;
  logic  ar_hs;
  logic  r_hs;
  logic  aw_hs;
  logic  w_hs;
  logic  b_hs;
  word_t rdata_q;

  assign is_mem   = op.ren | op.wen;
  // ops that never reach the bus
  assign start_ok = ~op.up_excp & ~ld_misalign & ~st_misalign;
  assign issue    = op.first & ~flush & is_mem & start_ok;

  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;
  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;

  // --------------------
  // request channels
  always_ff @(posedge clock) begin
    if (reset) begin
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      if (ar_hs) begin
        ar_valid <= 1'b0;
      end else if (issue && op.ren) begin
        ar_valid <= 1'b1;
      end
      if (aw_hs) begin
        aw_valid <= 1'b0;
      end else if (issue && op.wen) begin
        aw_valid <= 1'b1;
      end
      if (w_hs) begin
        w_valid <= 1'b0;
      end else if (issue && op.wen) begin
        w_valid <= 1'b1;
      end
    end
  end

  assign ar_addr = op.addr;
  assign ar_size = size;
  assign aw_addr = op.addr;
  assign aw_size = size;
  assign w_data  = wdata_lane;
  assign w_strb  = strb;

  // --------------------
  // response channels
  // ready drops after a response and comes back with the next request
  always_ff @(posedge clock) begin
    if (reset) begin
      r_ready <= 1'b1;
      b_ready <= 1'b1;
    end else begin
      if (ar_hs) begin
        r_ready <= 1'b1;
      end else if (r_hs) begin
        r_ready <= 1'b0;
      end
      if (b_hs) begin
        b_ready <= 1'b0;
      end else if (aw_hs || w_hs) begin
        b_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (r_hs) begin
      rdata_q <= r_data;
    end
  end

  assign rdata = r_hs ? r_data : rdata_q;

  // --------------------
  // retire and faults
  assign retire   = op.valid & ((op.first & ~flush & (~is_mem | ~start_ok)) | r_hs | b_hs);
  assign ld_fault = r_hs & r_resp[1];
  assign st_fault = b_hs & b_resp[1];

endmodule

/* lsu_lane_align.sv */
`timescale 1ns/100ps

module lsu_lane_align import lsu_pkg::*; (
  lsu_op_if.align op,
  input  word_t   rdata,
  output size_t   size,
  output strb_t   strb,
  output word_t   wdata_lane,
  output logic    ld_misalign,
  output logic    st_misalign,
  output word_t   load_data
);

  logic       is_half;
  logic       is_word;
  logic       bad_addr;
  logic [4:0] shamt;
  word_t      lane_mask;
  word_t      lane_data;

  assign shamt = {op.addr[1:0], 3'b000};

  // --------------------
  // size and byte strobes
  always_comb begin
    case (op.func3)
      MEM_B, MEM_BU: begin
        size = 3'd0;
        strb = 4'b0001 << op.addr[1:0];
      end
      MEM_H, MEM_HU: begin
        size = 3'd1;
        strb = op.addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        size = 3'd2;
        strb = 4'b1111;
      end
    endcase
  end

  assign wdata_lane = op.wdata << shamt;

  // --------------------
  // alignment check
  assign is_half  = (op.func3 == MEM_H) || (op.func3 == MEM_HU);
  assign is_word  = (op.func3 == MEM_W);
  assign bad_addr = (is_half && op.addr[0]) || (is_word && (op.addr[1:0] != 2'b00));

  assign ld_misalign = op.ren & bad_addr;
  assign st_misalign = op.wen & bad_addr;

  // --------------------
  // load extraction
  assign lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  // bytes outside the access are masked, so the unsigned forms are already zero-extended
  assign lane_data = (rdata & lane_mask) >> shamt;

  always_comb begin
    case (op.func3)
      MEM_B:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      MEM_H:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      default: load_data = lane_data;
    endcase
  end

endmodule

/* lsu_op_if.sv */
`timescale 1ns/100ps

interface lsu_op_if import lsu_pkg::*; ();

  // held operation, valid until it retires
  logic      valid;
  logic      first;
  word_t     addr;
  func3_t    func3;
  logic      ren;
  logic      wen;
  // store data, or csr write data for non-memory ops
  word_t     wdata;
  gpr_addr_t gpr_waddr;
  logic      gpr_wen;
  csr_addr_t csr_waddr;
  logic      csr_wen;
  logic      up_excp;
  cause_t    up_cause;
  logic      fencei;
  logic      mispred;
  word_t     pc;
  word_t     npc;

  modport stage (
    output valid, first, addr, func3, ren, wen, wdata, gpr_waddr, gpr_wen,
           csr_waddr, csr_wen, up_excp, up_cause, fencei, mispred, pc, npc
  );

  modport align (input addr, func3, ren, wen, wdata);

  modport bus (input valid, first, addr, ren, wen, up_excp);

  modport trap (
    input valid, addr, ren, wdata, gpr_waddr, gpr_wen, csr_waddr, csr_wen,
          up_excp, up_cause, fencei, mispred, pc, npc
  );

endinterface

/* lsu_pkg.sv */
package lsu_pkg;

  // --------------------
  // data and address widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [1:0]  csr_addr_t;
  typedef logic [3:0]  cause_t;

  // --------------------
  // memory access width, the func3 field of loads and stores
  typedef logic [2:0] func3_t;

  localparam func3_t MEM_B  = 3'd0;
  localparam func3_t MEM_H  = 3'd1;
  localparam func3_t MEM_W  = 3'd2;
  localparam func3_t MEM_BU = 3'd4;
  localparam func3_t MEM_HU = 3'd5;

  // csr selector toward the csr file
  localparam csr_addr_t CSR_MEPC = 2'd1;

  // --------------------
  // exception causes raised here
  localparam cause_t CAUSE_LD_MISALIGN = 4'd4;
  localparam cause_t CAUSE_LD_FAULT    = 4'd5;
  localparam cause_t CAUSE_ST_MISALIGN = 4'd6;
  localparam cause_t CAUSE_ST_FAULT    = 4'd7;

  // --------------------
  // bus fields
  typedef logic [3:0] strb_t;
  // 0 byte, 1 halfword, 2 word
  typedef logic [2:0] size_t;
  // bit 1 set means slave or decode error
  typedef logic [1:0] resp_t;

endpackage

/* lsu_stage_reg.sv */
`timescale 1ns/100ps

module lsu_stage_reg import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      in_valid,
  input  word_t     in_result,
  input  func3_t    in_func3,
  input  logic      in_ren,
  input  logic      in_wen,
  input  word_t     in_wdata,
  input  gpr_addr_t in_gpr_waddr,
  input  logic      in_gpr_wen,
  input  csr_addr_t in_csr_waddr,
  input  logic      in_csr_wen,
  input  logic      in_up_excp,
  input  cause_t    in_up_cause,
  input  logic      in_fencei,
  input  logic      in_mispred,
  input  word_t     in_pc,
  input  word_t     in_npc,
  output logic      in_ready,
  input  logic      retire,
  input  logic      flush,
  lsu_op_if.stage   op
);

  logic ready_q;
  logic capture;
  logic keep;

  // a retiring op frees the slot in the same cycle
  assign in_ready = ready_q | retire;
  assign capture  = in_valid & in_ready;
  // ops taken during a flush are wrong-path and dropped
  assign keep     = capture & ~flush;

  // --------------------
  // control
  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q  <= 1'b1;
      op.valid <= 1'b0;
      op.first <= 1'b0;
    end else begin
      op.first <= keep;
      if (keep) begin
        op.valid <= 1'b1;
        ready_q  <= ~(in_ren | in_wen);
      end else if (retire | flush) begin
        op.valid <= 1'b0;
        ready_q  <= 1'b1;
      end
    end
  end

  // --------------------
  // operation payload
  always_ff @(posedge clock) begin
    if (capture) begin
      op.addr      <= in_result;
      op.func3     <= in_func3;
      op.ren       <= in_ren;
      op.wen       <= in_wen;
      op.wdata     <= in_wdata;
      op.gpr_waddr <= in_gpr_waddr;
      op.gpr_wen   <= in_gpr_wen;
      op.csr_waddr <= in_csr_waddr;
      op.csr_wen   <= in_csr_wen;
      op.up_excp   <= in_up_excp;
      op.up_cause  <= in_up_cause;
      op.fencei    <= in_fencei;
      op.mispred   <= in_mispred;
      op.pc        <= in_pc;
      op.npc       <= in_npc;
    end
  end

endmodule

/* lsu_tb.sv */
`timescale 1ns/100ps

module lsu_tb import lsu_pkg::*; ();

  localparam int    MEM_WORDS  = 256;
  // any address with bit 31 set faults
  localparam word_t FAULT_BASE = 32'h8000_0000;
  localparam word_t TRAP_VEC   = 32'h0000_0200;
  localparam int    TIMEOUT    = 200;

  logic      clock;
  logic      reset;
  logic      in_valid;
  logic      in_ready;
  word_t     in_result;
  func3_t    in_func3;
  logic      in_ren;
  logic      in_wen;
  word_t     in_wdata;
  gpr_addr_t in_gpr_waddr;
  logic      in_gpr_wen;
  csr_addr_t in_csr_waddr;
  logic      in_csr_wen;
  logic      in_up_excp;
  cause_t    in_up_cause;
  logic      in_fencei;
  logic      in_mispred;
  word_t     in_pc;
  word_t     in_npc;
  word_t     trap_vector;
  logic      retire;
  word_t     result;
  logic      gpr_wen;
  gpr_addr_t gpr_waddr;
  logic      csr_wen;
  csr_addr_t csr_waddr;
  word_t     csr_wdata;
  logic      excp;
  cause_t    mcause;
  logic      flush;
  word_t     flush_pc;
  logic      flush_fencei;
  logic      ar_valid;
  word_t     ar_addr;
  size_t     ar_size;
  logic      ar_ready;
  logic      r_valid;
  word_t     r_data;
  resp_t     r_resp;
  logic      r_ready;
  logic      aw_valid;
  word_t     aw_addr;
  size_t     aw_size;
  logic      aw_ready;
  logic      w_valid;
  word_t     w_data;
  strb_t     w_strb;
  logic      w_ready;
  logic      b_valid;
  resp_t     b_resp;
  logic      b_ready;
  logic [2:0] mem_delay;

  // expected response of the op in flight
  word_t     exp_result;
  logic      exp_gpr_wen;
  logic      exp_csr_wen;
  csr_addr_t exp_csr_waddr;
  word_t     exp_csr_wdata;
  logic      exp_excp;
  cause_t    exp_cause;
  logic      exp_flush;
  word_t     exp_flush_pc;
  logic      exp_fencei;
  logic      exp_bus;
  size_t     exp_size;
  strb_t     exp_strb;
  word_t     exp_wdata;
  word_t     exp_wmask;

  word_t     lfsr_state;
  word_t     rnd;
  word_t     shadow [0:MEM_WORDS-1];
  string     test_name;
  int        value_errors;
  int        other_errors;
  logic      timed_out;
  logic      retire_seen;

  lsu_top uut (
    .clock, .reset, .in_valid, .in_ready, .in_result, .in_func3, .in_ren, .in_wen,
    .in_wdata, .in_gpr_waddr, .in_gpr_wen, .in_csr_waddr, .in_csr_wen, .in_up_excp,
    .in_up_cause, .in_fencei, .in_mispred, .in_pc, .in_npc, .trap_vector, .retire,
    .result, .gpr_wen, .gpr_waddr, .csr_wen, .csr_waddr, .csr_wdata, .excp, .mcause,
    .flush, .flush_pc, .flush_fencei, .ar_valid, .ar_addr, .ar_size, .ar_ready,
    .r_valid, .r_data, .r_resp, .r_ready, .aw_valid, .aw_addr, .aw_size, .aw_ready,
    .w_valid, .w_data, .w_strb, .w_ready, .b_valid, .b_resp, .b_ready
  );

  lsu_tb_mem bus_mem (
    .clock, .reset, .delay (mem_delay), .ar_valid, .ar_addr, .ar_ready, .r_valid,
    .r_data, .r_resp, .r_ready, .aw_valid, .aw_addr, .aw_ready, .w_valid, .w_data,
    .w_strb, .w_ready, .b_valid, .b_resp, .b_ready
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // --------------------
  // fibonacci lfsr with taps 32 22 2 1
  function automatic word_t lfsr_next(input word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t take_bits(input int n);
    word_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // initial memory contents as the responder fills them
  function automatic word_t fill_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a ^ 8'hc3, ~a, a, a ^ 8'h5a};
  endfunction

  function automatic word_t load_value(input func3_t f, input word_t a);
    word_t w;
    w = shadow[a[9:2]] >> {a[1:0], 3'b000};
    case (f)
      MEM_B:   return {{24{w[7]}}, w[7:0]};
      MEM_H:   return {{16{w[15]}}, w[15:0]};
      MEM_BU:  return {24'h0, w[7:0]};
      MEM_HU:  return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  // --------------------
  // reference model of one op from the fields on the input ports
  function automatic void compute_expected();
    logic is_mem;
    logic mis;
    logic fault;
    int   lane;
    int   nbytes;
    is_mem = in_ren | in_wen;
    mis    = is_mem && ((((in_func3 == MEM_H) || (in_func3 == MEM_HU)) && in_result[0])
             || ((in_func3 == MEM_W) && (in_result[1:0] != 2'b00)));
    fault  = is_mem && !in_up_excp && !mis && in_result[31];
    exp_excp = in_up_excp | mis | fault;
    if (in_up_excp) begin
      exp_cause = in_up_cause;
    end else if (mis) begin
      exp_cause = in_ren ? CAUSE_LD_MISALIGN : CAUSE_ST_MISALIGN;
    end else if (fault) begin
      exp_cause = in_ren ? CAUSE_LD_FAULT : CAUSE_ST_FAULT;
    end else begin
      exp_cause = 4'd0;
    end
    exp_bus       = is_mem && !in_up_excp && !mis;
    exp_result    = in_ren ? load_value(in_func3, in_result) : in_result;
    exp_gpr_wen   = in_gpr_wen & ~exp_excp;
    exp_csr_wen   = in_csr_wen | exp_excp;
    exp_csr_waddr = exp_excp ? CSR_MEPC : in_csr_waddr;
    exp_csr_wdata = exp_excp ? in_pc : in_wdata;
    exp_flush     = exp_excp | in_mispred | in_fencei;
    exp_flush_pc  = exp_excp ? TRAP_VEC : in_npc;
    exp_fencei    = in_fencei;

    // bus size and byte lanes of the access
    case (in_func3)
      MEM_B, MEM_BU: begin
        exp_size = 3'd0;
        nbytes   = 1;
      end
      MEM_H, MEM_HU: begin
        exp_size = 3'd1;
        nbytes   = 2;
      end
      default: begin
        exp_size = 3'd2;
        nbytes   = 4;
      end
    endcase
    lane      = in_result[1:0];
    exp_strb  = '0;
    exp_wdata = '0;
    exp_wmask = '0;
    if (exp_bus) begin
      for (int k = 0; k < nbytes; k++) begin
        exp_strb[lane+k]           = 1'b1;
        exp_wdata[8*(lane+k) +: 8] = in_wdata[8*k +: 8];
        exp_wmask[8*(lane+k) +: 8] = 8'hff;
      end
    end
  endfunction

  task automatic store_shadow();
    int idx;
    int lane;
    int nbytes;
    idx    = in_result[9:2];
    lane   = in_result[1:0];
    nbytes = (in_func3 == MEM_B) ? 1 : (in_func3 == MEM_H) ? 2 : 4;
    for (int k = 0; k < nbytes; k++) begin
      shadow[idx][8*(lane+k) +: 8] = in_wdata[8*k +: 8];
    end
  endtask

  task automatic compare_field(input string what, input word_t exp_v, input word_t act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      value_errors++;
    end
  endtask

  // --------------------
  // compare at every retire and at the cycle after it
  always @(posedge clock) begin
    if (reset) begin
      retire_seen <= 1'b0;
    end else begin
      if (!exp_bus && (ar_valid || aw_valid || w_valid)) begin
        $display("%s: bus request raised by an op that must stay off the bus", test_name);
        other_errors++;
      end
      if (ar_valid) begin
        compare_field("ar_addr", in_result, ar_addr);
        compare_field("ar_size", exp_size, ar_size);
      end
      if (aw_valid) begin
        compare_field("aw_addr", in_result, aw_addr);
        compare_field("aw_size", exp_size, aw_size);
      end
      if (w_valid) begin
        compare_field("w_strb", exp_strb, w_strb);
        compare_field("w_data", exp_wdata, w_data & exp_wmask);
      end
      if (retire) begin
        compare_field("excp", exp_excp, excp);
        compare_field("gpr_wen", exp_gpr_wen, gpr_wen);
        compare_field("csr_wen", exp_csr_wen, csr_wen);
        if (exp_excp) begin
          compare_field("mcause", exp_cause, mcause);
        end else begin
          compare_field("result", exp_result, result);
        end
        if (exp_gpr_wen) begin
          compare_field("gpr_waddr", in_gpr_waddr, gpr_waddr);
        end
        if (exp_csr_wen) begin
          compare_field("csr_waddr", exp_csr_waddr, csr_waddr);
          compare_field("csr_wdata", exp_csr_wdata, csr_wdata);
        end
      end
      if (retire_seen) begin
        compare_field("flush", exp_flush, flush);
        compare_field("flush_fencei", exp_fencei, flush_fencei);
        if (exp_flush) begin
          compare_field("flush_pc", exp_flush_pc, flush_pc);
        end
      end else if (flush) begin
        $display("%s: flush raised without a retire in the cycle before", test_name);
        other_errors++;
      end
      retire_seen <= retire;
    end
  end

  // --------------------
  // stimulus
  task automatic new_op();
    in_result    = '0;
    in_func3     = MEM_W;
    in_ren       = 1'b0;
    in_wen       = 1'b0;
    in_wdata     = take_bits(32);
    rnd          = take_bits(5);
    in_gpr_waddr = rnd[4:0];
    in_gpr_wen   = 1'b1;
    in_csr_waddr = 2'd0;
    in_csr_wen   = 1'b0;
    in_up_excp   = 1'b0;
    in_up_cause  = 4'd0;
    in_fencei    = 1'b0;
    in_mispred   = 1'b0;
    in_pc        = take_bits(30) << 2;
    in_npc       = in_pc + 32'd4;
  endtask

  task automatic issue_op(input string name);
    int waited;
    if (!timed_out) begin
      test_name = name;
      compute_expected();
      rnd       = take_bits(3);
      mem_delay = rnd[2:0];
      in_valid  = 1'b1;
      waited    = 0;
      @(posedge clock);
      while (!in_ready && waited < TIMEOUT) begin
        @(posedge clock);
        waited++;
      end
      if (!in_ready) begin
        $display("%s: no in_ready within %0d cycles", name, TIMEOUT);
        other_errors++;
        timed_out = 1'b1;
      end
      #10;
      in_valid = 1'b0;
      if (!timed_out) begin
        waited = 0;
        @(posedge clock);
        while (!retire && waited < TIMEOUT) begin
          @(posedge clock);
          waited++;
        end
        if (!retire) begin
          $display("%s: no retire within %0d cycles", name, TIMEOUT);
          other_errors++;
          timed_out = 1'b1;
        end else begin
          if (in_wen && !exp_excp) begin
            store_shadow();
          end
          // flush is checked at this edge
          @(posedge clock);
          #10;
        end
      end
    end
  endtask

  // aligned address inside the memory for the given width
  function automatic word_t mem_addr(input func3_t f);
    word_t a;
    a = take_bits(8) << 2;
    if ((f == MEM_B) || (f == MEM_BU)) begin
      a = a | take_bits(2);
    end else if ((f == MEM_H) || (f == MEM_HU)) begin
      a = a | (take_bits(1) << 1);
    end
    return a;
  endfunction

  function automatic func3_t pick_load();
    word_t r;
    r = take_bits(3);
    case (r[2:0])
      3'd0, 3'd6: return MEM_B;
      3'd1, 3'd7: return MEM_H;
      3'd3:       return MEM_BU;
      3'd4:       return MEM_HU;
      default:    return MEM_W;
    endcase
  endfunction

  function automatic func3_t pick_store();
    word_t r;
    r = take_bits(2);
    case (r[1:0])
      2'd0:    return MEM_B;
      2'd1:    return MEM_H;
      default: return MEM_W;
    endcase
  endfunction

  task automatic mem_op(input string name, input logic is_load, input func3_t f,
                        input word_t a);
    new_op();
    in_ren     = is_load;
    in_wen     = ~is_load;
    in_gpr_wen = is_load;
    in_func3   = f;
    in_result  = a;
    issue_op(name);
  endtask

  initial begin
    int i;
    lfsr_state   = 32'h43f2_dfcd;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    test_name    = "reset";
    exp_bus      = 1'b0;
    trap_vector  = TRAP_VEC;
    in_valid     = 1'b0;
    mem_delay    = 3'd0;
    new_op();
    for (i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = fill_word(i);
    end
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #10;
    reset = 1'b0;

    // plain alu results with an occasional csr write
    for (i = 0; i < 8; i++) begin
      new_op();
      in_result    = take_bits(32);
      rnd          = take_bits(3);
      in_csr_wen   = rnd[0];
      in_csr_waddr = rnd[2:1];
      issue_op("alu");
    end

    // random aligned stores and loads
    for (i = 0; i < 80; i++) begin
      rnd = take_bits(1);
      if (rnd[0]) begin
        in_func3 = pick_store();
        mem_op("store", 1'b0, in_func3, mem_addr(in_func3));
      end else begin
        in_func3 = pick_load();
        mem_op("load", 1'b1, in_func3, mem_addr(in_func3));
      end
    end

    // misaligned ops stay off the bus
    mem_op("misalign", 1'b1, MEM_H, mem_addr(MEM_W) | 32'd1);
    mem_op("misalign", 1'b1, MEM_HU, mem_addr(MEM_W) | 32'd3);
    mem_op("misalign", 1'b1, MEM_W, mem_addr(MEM_W) | 32'd2);
    mem_op("misalign", 1'b0, MEM_H, mem_addr(MEM_W) | 32'd1);
    mem_op("misalign", 1'b0, MEM_W, mem_addr(MEM_W) | 32'd3);

    // fault region
    mem_op("fault", 1'b1, MEM_W, FAULT_BASE | 32'h40);
    mem_op("fault", 1'b1, MEM_B, FAULT_BASE | 32'h43);
    mem_op("fault", 1'b0, MEM_W, FAULT_BASE | 32'h44);

    // redirects
    new_op();
    in_result  = take_bits(32);
    in_mispred = 1'b1;
    in_npc     = take_bits(30) << 2;
    issue_op("mispred");
    new_op();
    in_gpr_wen = 1'b0;
    in_fencei  = 1'b1;
    issue_op("fencei");

    // upstream cause wins over misalignment and faults
    new_op();
    in_ren      = 1'b1;
    in_func3    = MEM_W;
    in_result   = mem_addr(MEM_W) | 32'd2;
    in_up_excp  = 1'b1;
    in_up_cause = 4'd2;
    issue_op("up_excp");
    new_op();
    in_wen      = 1'b1;
    in_gpr_wen  = 1'b0;
    in_result   = FAULT_BASE | 32'h80;
    in_up_excp  = 1'b1;
    in_up_cause = 4'd1;
    issue_op("up_excp");

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* lsu_tb_mem.sv */
`timescale 1ns/100ps

module lsu_tb_mem import lsu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  // ready and response delay in cycles
  input  logic [2:0] delay,
  input  logic       ar_valid,
  input  word_t      ar_addr,
  output logic       ar_ready,
  output logic       r_valid,
  output word_t      r_data,
  output resp_t      r_resp,
  input  logic       r_ready,
  input  logic       aw_valid,
  input  word_t      aw_addr,
  output logic       aw_ready,
  input  logic       w_valid,
  input  word_t      w_data,
  input  strb_t      w_strb,
  output logic       w_ready,
  output logic       b_valid,
  output resp_t      b_resp,
  input  logic       b_ready
);

  localparam int DEPTH = 256;

  word_t      mem [0:DEPTH-1];
  logic [1:0] phase;
  logic [2:0] count;
  logic       is_read;
  integer     i;

  initial begin
    for (i = 0; i < DEPTH; i = i + 1) begin
      mem[i] = {i[7:0] ^ 8'hc3, ~i[7:0], i[7:0], i[7:0] ^ 8'h5a};
    end
    ar_ready = 1'b0;
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    r_valid  = 1'b0;
    b_valid  = 1'b0;
    r_data   = '0;
    r_resp   = '0;
    b_resp   = '0;
  end

  // --------------------
  // 0 idle, 1 ready delay, 2 response delay, 3 response held
  always @(posedge clock) begin
    if (reset) begin
      phase    <= 2'd0;
      count    <= 3'd0;
      is_read  <= 1'b0;
      ar_ready <= 1'b0;
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      r_valid  <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      ar_ready <= 1'b0;
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      case (phase)
        2'd0: begin
          // a write waits for both address and data
          if (ar_valid || (aw_valid && w_valid)) begin
            is_read <= ar_valid;
            count   <= delay;
            phase   <= 2'd1;
          end
        end
        2'd1: begin
          if (count != 3'd0) begin
            count <= count - 3'd1;
          end else begin
            ar_ready <= is_read;
            aw_ready <= ~is_read;
            w_ready  <= ~is_read;
            if (is_read) begin
              r_data <= ar_addr[31] ? 32'h0 : mem[ar_addr[9:2]];
              r_resp <= ar_addr[31] ? 2'b10 : 2'b00;
            end else begin
              b_resp <= aw_addr[31] ? 2'b10 : 2'b00;
              if (!aw_addr[31]) begin
                if (w_strb[0]) mem[aw_addr[9:2]][7:0]   <= w_data[7:0];
                if (w_strb[1]) mem[aw_addr[9:2]][15:8]  <= w_data[15:8];
                if (w_strb[2]) mem[aw_addr[9:2]][23:16] <= w_data[23:16];
                if (w_strb[3]) mem[aw_addr[9:2]][31:24] <= w_data[31:24];
              end
            end
            count <= {delay[0], delay[2:1]};
            phase <= 2'd2;
          end
        end
        2'd2: begin
          if (count != 3'd0) begin
            count <= count - 3'd1;
          end else begin
            r_valid <= is_read;
            b_valid <= ~is_read;
            phase   <= 2'd3;
          end
        end
        default: begin
          if ((r_valid && r_ready) || (b_valid && b_ready)) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            phase   <= 2'd0;
          end
        end
      endcase
    end
  end

endmodule

/* lsu_top.sv */
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // from execute
  input  logic      in_valid,
  output logic      in_ready,
  input  word_t     in_result,
  input  func3_t    in_func3,
  input  logic      in_ren,
  input  logic      in_wen,
  input  word_t     in_wdata,
  input  gpr_addr_t in_gpr_waddr,
  input  logic      in_gpr_wen,
  input  csr_addr_t in_csr_waddr,
  input  logic      in_csr_wen,
  input  logic      in_up_excp,
  input  cause_t    in_up_cause,
  input  logic      in_fencei,
  input  logic      in_mispred,
  input  word_t     in_pc,
  input  word_t     in_npc,
  input  word_t     trap_vector,
  // writeback and csr
  output logic      retire,
  output word_t     result,
  output logic      gpr_wen,
  output gpr_addr_t gpr_waddr,
  output logic      csr_wen,
  output csr_addr_t csr_waddr,
  output word_t     csr_wdata,
  output logic      excp,
  output cause_t    mcause,
  // redirect toward fetch
  output logic      flush,
  output word_t     flush_pc,
  output logic      flush_fencei,
  // memory bus
  output logic      ar_valid,
  output word_t     ar_addr,
  output size_t     ar_size,
  input  logic      ar_ready,
  input  logic      r_valid,
  input  word_t     r_data,
  input  resp_t     r_resp,
  output logic      r_ready,
  output logic      aw_valid,
  output word_t     aw_addr,
  output size_t     aw_size,
  input  logic      aw_ready,
  output logic      w_valid,
  output word_t     w_data,
  output strb_t     w_strb,
  input  logic      w_ready,
  input  logic      b_valid,
  input  resp_t     b_resp,
  output logic      b_ready
);

  logic  ld_fault;
  logic  st_fault;
  logic  ld_misalign;
  logic  st_misalign;
  word_t rdata;
  word_t load_data;
  word_t wdata_lane;
  size_t size;
  strb_t strb;

  lsu_op_if op ();

  lsu_stage_reg u_stage_reg (
    .clock, .reset, .in_valid, .in_result, .in_func3, .in_ren, .in_wen, .in_wdata,
    .in_gpr_waddr, .in_gpr_wen, .in_csr_waddr, .in_csr_wen, .in_up_excp, .in_up_cause,
    .in_fencei, .in_mispred, .in_pc, .in_npc, .in_ready, .retire, .flush,
    .op (op.stage)
  );

  lsu_lane_align u_lane_align (
    .op (op.align), .rdata, .size, .strb, .wdata_lane, .ld_misalign, .st_misalign,
    .load_data
  );

  lsu_bus_master u_bus_master (
    .clock, .reset, .op (op.bus), .ld_misalign, .st_misalign, .flush, .size, .strb,
    .wdata_lane, .ar_valid, .ar_addr, .ar_size, .ar_ready, .r_valid, .r_data, .r_resp,
    .r_ready, .aw_valid, .aw_addr, .aw_size, .aw_ready, .w_valid, .w_data, .w_strb,
    .w_ready, .b_valid, .b_resp, .b_ready, .rdata, .retire, .ld_fault, .st_fault
  );

  lsu_trap_flush u_trap_flush (
    .clock, .reset, .op (op.trap), .retire, .ld_fault, .st_fault, .ld_misalign,
    .st_misalign, .load_data, .trap_vector, .result, .gpr_wen, .gpr_waddr, .csr_wen,
    .csr_waddr, .csr_wdata, .excp, .mcause, .flush, .flush_pc, .flush_fencei
  );

endmodule

/* lsu_trap_flush.sv */
`timescale 1ns/100ps

module lsu_trap_flush import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  lsu_op_if.trap    op,
  input  logic      retire,
  input  logic      ld_fault,
  input  logic      st_fault,
  input  logic      ld_misalign,
  input  logic      st_misalign,
  input  word_t     load_data,
  input  word_t     trap_vector,
  output word_t     result,
  output logic      gpr_wen,
  output gpr_addr_t gpr_waddr,
  output logic      csr_wen,
  output csr_addr_t csr_waddr,
  output word_t     csr_wdata,
  output logic      excp,
  output cause_t    mcause,
  output logic      flush,
  output word_t     flush_pc,
  output logic      flush_fencei
);

  logic gen_flush;

  // --------------------
  // exception select
  assign excp = op.valid & (op.up_excp | ld_misalign | st_misalign | ld_fault | st_fault);

  // upstream first, then alignment, then bus faults
  always_comb begin
    if (op.up_excp) begin
      mcause = op.up_cause;
    end else if (ld_misalign) begin
      mcause = CAUSE_LD_MISALIGN;
    end else if (st_misalign) begin
      mcause = CAUSE_ST_MISALIGN;
    end else if (ld_fault) begin
      mcause = CAUSE_LD_FAULT;
    end else if (st_fault) begin
      mcause = CAUSE_ST_FAULT;
    end else begin
      mcause = 4'd0;
    end
  end

  // trap writes mepc, otherwise the op's own csr write
  assign csr_wen   = retire & (op.csr_wen | excp);
  assign csr_waddr = excp ? CSR_MEPC : op.csr_waddr;
  assign csr_wdata = excp ? op.pc : op.wdata;

  // --------------------
  // register file write
  assign result    = op.ren ? load_data : op.addr;
  assign gpr_wen   = retire & op.gpr_wen & ~excp;
  assign gpr_waddr = op.gpr_waddr;

  // --------------------
  // flush pulse
  assign gen_flush = retire & (excp | op.mispred | op.fencei);

  always_ff @(posedge clock) begin
    if (reset) begin
      flush        <= 1'b0;
      flush_fencei <= 1'b0;
    end else begin
      flush        <= gen_flush;
      flush_fencei <= gen_flush & op.fencei;
    end
  end

  always_ff @(posedge clock) begin
    if (gen_flush) begin
      flush_pc <= excp ? trap_vector : op.npc;
    end
  end

endmodule

/* src.f */
lsu_pkg.sv
lsu_op_if.sv
lsu_stage_reg.sv
lsu_lane_align.sv
lsu_bus_master.sv
lsu_trap_flush.sv
lsu_top.sv
lsu_tb_mem.sv
lsu_tb.sv
